// File: src.f
+incdir+rtl
rtl/mem_pkg.sv
rtl/load_unit.sv
rtl/data_memory.sv
rtl/memory_stage.sv
rtl/mem_top.sv
sim/tb_mem_top.sv

// File: Bender.yml
package:
  name: mem_stage

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mem_pkg.sv
      - rtl/load_unit.sv
      - rtl/data_memory.sv
      - rtl/memory_stage.sv
      - rtl/mem_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/tb_mem_top.sv

// File: sim/tb_mem_top.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module tb_mem_top import mem_pkg::*; ();

  localparam int TIMEOUT = 20;

  typedef enum logic [3:0] {
    OP_ALU, OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW, OP_FENCE
  } op_e;

  typedef struct packed {
    op_e         op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [4:0]  rd;
    logic        clr;
    logic        exp_wren;
    logic [31:0] exp_wdata;
  } entry_t;

  logic               clk;
  logic               rst;
  logic               clear;
  logic               stall;
  execute_out_type    ex;
  register_write_type reg_w;
  register_write_type fwd;

  entry_t      tab[$];
  logic [7:0]  ref_mem [`MEM_WORDS*4];
  logic        prev_wren;
  logic [4:0]  prev_waddr;
  logic [31:0] prev_wdata;
  integer      seed;

  mem_top u_dut (
    .clk   (clk),
    .rst   (rst),
    .ex    (ex),
    .clear (clear),
    .stall (stall),
    .reg_w (reg_w),
    .fwd   (fwd)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic is_load(input op_e op);
    return (op == OP_LB) || (op == OP_LH) || (op == OP_LW) || (op == OP_LBU) || (op == OP_LHU);
  endfunction

  function automatic logic is_store(input op_e op);
    return (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
  endfunction

  // little endian byte store into the model.
  task automatic store_ref(input op_e op, input logic [31:0] addr, input logic [31:0] data);
    int n;
    int base;
    n    = (op == OP_SB) ? 1 : (op == OP_SH) ? 2 : 4;
    base = addr % (`MEM_WORDS*4);
    base = base - (base % n);
    for (int k = 0; k < n; k++) begin
      ref_mem[base+k] = data[8*k +: 8];
    end
  endtask

  function automatic logic [31:0] load_ref(input op_e op, input logic [31:0] addr);
    int          a;
    logic [7:0]  b;
    logic [15:0] h;
    logic [31:0] w;
    a = addr % (`MEM_WORDS*4);
    b = ref_mem[a];
    h = {ref_mem[a - a%2 + 1], ref_mem[a - a%2]};
    w = {ref_mem[a - a%4 + 3], ref_mem[a - a%4 + 2], ref_mem[a - a%4 + 1], ref_mem[a - a%4]};
    case (op)
      OP_LB:   return {{24{b[7]}}, b};
      OP_LBU:  return {24'd0, b};
      OP_LH:   return {{16{h[15]}}, h};
      OP_LHU:  return {16'd0, h};
      default: return w;
    endcase
  endfunction

  // the model runs in table order, as the memory serves requests in order.
  task automatic add_entry(input op_e op, input logic [31:0] addr, input logic [31:0] data,
                           input logic [4:0] rd, input logic clr);
    entry_t e;
    e = '{op: op, addr: addr, data: data, rd: rd, clr: clr, exp_wren: 1'b0, exp_wdata: '0};
    if (is_store(op)) store_ref(op, addr, data);
    if (is_load(op)) e.exp_wdata = load_ref(op, addr);
    if (op == OP_ALU) e.exp_wdata = data;
    e.exp_wren = ((op == OP_ALU) || is_load(op)) && (rd != 0) && !clr;
    tab.push_back(e);
  endtask

  task automatic drive_entry(input entry_t e, input logic en, input logic [31:0] pc);
    execute_out_type x;
    x = '0;
    x.pc      = pc;
    x.valid   = en;
    x.waddr   = e.rd;
    x.address = e.addr;
    x.sdata   = e.data;
    x.load    = is_load(e.op);
    x.store   = is_store(e.op);
    x.fence   = (e.op == OP_FENCE);
    x.wren    = (e.op == OP_ALU) || x.load;
    x.wdata   = (e.op == OP_ALU) ? e.data : '0;
    case (e.op)
      OP_LB:  x.lsu_op.lsu_lb  = 1'b1;
      OP_LH:  x.lsu_op.lsu_lh  = 1'b1;
      OP_LW:  x.lsu_op.lsu_lw  = 1'b1;
      OP_LBU: x.lsu_op.lsu_lbu = 1'b1;
      OP_LHU: x.lsu_op.lsu_lhu = 1'b1;
      OP_SB:  x.lsu_op.lsu_sb  = 1'b1;
      OP_SH:  x.lsu_op.lsu_sh  = 1'b1;
      OP_SW:  x.lsu_op.lsu_sw  = 1'b1;
      default: ;
    endcase
    if ((e.op == OP_LB) || (e.op == OP_LBU) || (e.op == OP_SB)) begin
      x.byteenable = 4'b0001 << e.addr[1:0];
    end else if ((e.op == OP_LH) || (e.op == OP_LHU) || (e.op == OP_SH)) begin
      x.byteenable = e.addr[1] ? 4'b1100 : 4'b0011;
    end else if (x.load || x.store) begin
      x.byteenable = 4'b1111;
    end
    ex = x;
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Verification failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // reg_w against this cycle, fwd against the previous one.
  task automatic check_ports(input logic wren, input logic [4:0] waddr, input logic [31:0] wdata);
    check_value(reg_w.wren, wren, "reg_w.wren");
    if (wren) begin
      check_value(reg_w.waddr, waddr, "reg_w.waddr");
      check_value(reg_w.wdata, wdata, "reg_w.wdata");
    end
    check_value(fwd.wren, prev_wren, "fwd.wren");
    if (prev_wren) begin
      check_value(fwd.waddr, prev_waddr, "fwd.waddr");
      check_value(fwd.wdata, prev_wdata, "fwd.wdata");
    end
    prev_wren  = wren;
    prev_waddr = waddr;
    prev_wdata = wdata;
  endtask

  task automatic build_table();
    op_e         lops[5];
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] r;
    op_e         lop;
    lops = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    add_entry(OP_ALU, 32'h0, 32'h1234_5678, 5'd5, 1'b0);
    add_entry(OP_ALU, 32'h0, 32'hdead_beef, 5'd6, 1'b0);
    add_entry(OP_SW, 32'h40, 32'ha5a5_5a5a, 5'd0, 1'b0);
    add_entry(OP_LW, 32'h40, 32'h0, 5'd7, 1'b0);
    add_entry(OP_SW, 32'h80, 32'h1122_3344, 5'd0, 1'b0);
    add_entry(OP_SB, 32'h81, 32'h0000_00f0, 5'd0, 1'b0);
    add_entry(OP_SH, 32'h82, 32'h0000_8001, 5'd0, 1'b0);
    add_entry(OP_LB, 32'h81, 32'h0, 5'd8, 1'b0);
    add_entry(OP_LBU, 32'h81, 32'h0, 5'd9, 1'b0);
    add_entry(OP_LH, 32'h82, 32'h0, 5'd10, 1'b0);
    add_entry(OP_LHU, 32'h82, 32'h0, 5'd11, 1'b0);
    add_entry(OP_LBU, 32'h80, 32'h0, 5'd12, 1'b0);  // untouched lane.
    add_entry(OP_LW, 32'h80, 32'h0, 5'd13, 1'b0);
    add_entry(OP_LW, 32'h80, 32'h0, 5'd0, 1'b0);
    add_entry(OP_ALU, 32'h0, 32'h0bad_f00d, 5'd0, 1'b0);
    add_entry(OP_FENCE, 32'h0, 32'h0, 5'd3, 1'b0);
    add_entry(OP_ALU, 32'h0, 32'hcafe_0001, 5'd14, 1'b0);
    add_entry(OP_ALU, 32'h0, 32'hcafe_0002, 5'd15, 1'b1);
    add_entry(OP_LW, 32'h40, 32'h0, 5'd16, 1'b0);
    for (int k = 0; k < 8; k++) begin
      a   = $random(seed) & (`MEM_WORDS*4 - 4);
      d   = $random(seed);
      r   = $random(seed);
      lop = lops[r[31:8] % 5];
      add_entry(OP_SW, a, d, 5'd0, 1'b0);
      if ((lop == OP_LB) || (lop == OP_LBU)) a = a | r[1:0];
      if ((lop == OP_LH) || (lop == OP_LHU)) a = a | {r[1], 1'b0};
      add_entry(lop, a, 32'h0, 5'(17 + k), 1'b0);
    end
  endtask

  initial begin
    int     stalls;
    entry_t idle;
    rst        = 1'b0;
    clear      = 1'b0;
    ex         = '0;
    idle       = '0;
    prev_wren  = 1'b0;
    prev_waddr = '0;
    prev_wdata = '0;
    seed       = 15884;
    build_table();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    for (int i = 0; i <= tab.size(); i++) begin
      if (i < tab.size()) begin
        drive_entry(tab[i], 1'b1, 32'(i * 4));
      end else begin
        drive_entry(idle, 1'b0, 32'h0);
      end
      clear  = (i > 0) ? tab[i-1].clr : 1'b0;  // clear hits the entry now in memory.
      stalls = 0;
      #2;
      while (stall !== 1'b0) begin
        check_ports(1'b0, 5'd0, 32'h0);
        stalls++;
        if (stalls > TIMEOUT) begin
          $display("timeout at %0t ns: the DUT did not respond, stall stayed high", $time);
          $display("Verification failed");
          $fatal(1, "timeout");
        end
        @(negedge clk);
        #2;
      end
      if (i > 0) begin
        check_value(stalls, (is_load(tab[i-1].op) || is_store(tab[i-1].op) ||
                             (tab[i-1].op == OP_FENCE)) ? `MEM_WAIT + 1 : 0, "stall cycles");
        check_ports(tab[i-1].exp_wren, tab[i-1].rd, tab[i-1].exp_wdata);
      end else begin
        check_ports(1'b0, 5'd0, 32'h0);
      end
      @(negedge clk);
    end
    clear = 1'b0;
    #2;
    check_ports(1'b0, 5'd0, 32'h0);
    $display("Verification passed");
    $finish;
  end

endmodule

// File: rtl/mem_top.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_top import mem_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  execute_out_type    ex,
  input  logic               clear,
  output logic               stall,
  output register_write_type reg_w,
  output register_write_type fwd
);

  mem_in_type       mem_req;
  mem_out_type      mem_rsp;
  lsu_in_type       lsu_req;
  logic [`XLEN-1:0] load_result;

  memory_stage u_stage (
    .clk         (clk),
    .rst         (rst),
    .ex          (ex),
    .clear       (clear),
    .mem_rsp     (mem_rsp),
    .mem_req     (mem_req),
    .load_result (load_result),
    .lsu_req     (lsu_req),
    .reg_w       (reg_w),
    .fwd         (fwd),
    .stall       (stall)
  );

  load_unit u_load (
    .lsu_req (lsu_req),
    .result  (load_result)
  );

  data_memory u_mem (
    .clk     (clk),
    .rst     (rst),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

endmodule

// File: rtl/memory_stage.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module memory_stage import mem_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  execute_out_type    ex,
  input  logic               clear,
  input  mem_out_type        mem_rsp,
  output mem_in_type         mem_req,
  input  logic [`XLEN-1:0]   load_result,
  output lsu_in_type         lsu_req,
  output register_write_type reg_w,
  output register_write_type fwd,
  output logic               stall
);

  memory_reg_type     r;
  memory_reg_type     rin;
  memory_reg_type     v;
  register_write_type fwd_r;

  always_comb begin

    v = r;

    // a stalled instruction gets its enables back.
    if (r.stall == 1) begin
      v.wren  = r.wren_b;
      v.valid = r.valid_b;
      v.fence = r.fence_b;
    end

    v.clear = clear;
    v.stall = 0;

    // address phase, taken from the instruction in execute.
    mem_req.mem_valid = ex.valid & (ex.load | ex.store | ex.fence);
    mem_req.mem_fence = ex.fence;
    mem_req.mem_addr  = ex.address;
    mem_req.mem_wdata = store_data(ex.sdata, ex.lsu_op.lsu_sb, ex.lsu_op.lsu_sh,
                                   ex.lsu_op.lsu_sw);
    mem_req.mem_wstrb = (ex.load == 1) ? 4'h0 : ex.byteenable;

    lsu_req.ldata      = mem_rsp.mem_rdata;
    lsu_req.byteenable = v.byteenable;
    lsu_req.lsu_op     = v.lsu_op;

    if (v.valid == 1) begin
      if (v.load == 1) begin
        v.wdata = load_result;
        v.stall = ~mem_rsp.mem_ready;
      end else if (v.store == 1) begin
        v.stall = ~mem_rsp.mem_ready;
      end else if (v.fence == 1) begin
        v.stall = ~mem_rsp.mem_ready;
      end
    end

    v.wren_b  = v.wren;
    v.valid_b = v.valid;
    v.fence_b = v.fence;

    if ((v.stall | v.clear) == 1) begin
      v.wren  = 0;
      v.valid = 0;
      v.fence = 0;
    end

    // a cancelled instruction must not hold the pipe.
    if (v.clear == 1) begin
      v.stall = 0;
    end

    reg_w.wren  = v.wren & |(v.waddr);  // x0 is never written.
    reg_w.waddr = v.waddr;
    reg_w.wdata = v.wdata;

    stall = v.stall;

    rin = v;

    // no stall: the instruction in execute moves in.
    if (v.stall == 0) begin
      rin.valid      = ex.valid;
      rin.wren       = ex.wren;
      rin.waddr      = ex.waddr;
      rin.wdata      = ex.wdata;
      rin.load       = ex.load;
      rin.store      = ex.store;
      rin.fence      = ex.fence;
      rin.byteenable = ex.byteenable;
      rin.lsu_op     = ex.lsu_op;
    end

    fwd = fwd_r;

  end

  always_ff @(posedge clk) begin
    if (rst == 0) begin
      r     <= init_memory_reg;
      fwd_r <= '0;
    end else begin
      r     <= rin;
      fwd_r <= reg_w;
    end
  end

endmodule

// File: rtl/data_memory.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module data_memory import mem_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  mem_in_type  mem_req,
  output mem_out_type mem_rsp
);

  localparam int AW = $clog2(`MEM_WORDS);
  localparam int CW = ($clog2(`MEM_WAIT + 1) > 0) ? $clog2(`MEM_WAIT + 1) : 1;

  logic [`XLEN-1:0] ram [`MEM_WORDS];
  logic [`XLEN-1:0] rdata;
  logic             busy;
  logic             ready;
  logic [CW-1:0]    cnt;
  logic             accept;
  logic [AW-1:0]    idx;

  // busy clears in the edge that raises ready, so a new request
  // is taken in the response cycle.
  assign accept = mem_req.mem_valid & ~busy;
  assign idx    = mem_req.mem_addr[AW+1:2];

  always_ff @(posedge clk) begin
    if (rst == 0) begin
      busy  <= 1'b0;
      ready <= 1'b0;
      cnt   <= '0;
    end else begin
      ready <= 1'b0;
      if (accept == 1) begin
        busy <= 1'b1;
        cnt  <= CW'(`MEM_WAIT);
      end else if (busy == 1) begin
        if (cnt == 0) begin
          busy  <= 1'b0;
          ready <= 1'b1;  // one cycle pulse.
        end else begin
          cnt <= cnt - 1'b1;
        end
      end
    end
  end

  // read old word and apply the strobe write at acceptance.
  always_ff @(posedge clk) begin
    if (accept == 1) begin
      rdata <= ram[idx];
      if (mem_req.mem_fence == 0) begin
        for (int i = 0; i < `XLEN/8; i++) begin
          if (mem_req.mem_wstrb[i] == 1) begin
            ram[idx][8*i +: 8] <= mem_req.mem_wdata[8*i +: 8];
          end
        end
      end
    end
  end

  assign mem_rsp.mem_ready = ready;
  assign mem_rsp.mem_rdata = rdata;

endmodule

// File: rtl/load_unit.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module load_unit import mem_pkg::*; (
  input  lsu_in_type       lsu_req,
  output logic [`XLEN-1:0] result
);

  logic [7:0]  lane_b;
  logic [15:0] lane_h;

  // lane select from the byte enables.
  always_comb begin
    case (lsu_req.byteenable)
      4'b0010: lane_b = lsu_req.ldata[15:8];
      4'b0100: lane_b = lsu_req.ldata[23:16];
      4'b1000: lane_b = lsu_req.ldata[31:24];
      default: lane_b = lsu_req.ldata[7:0];
    endcase
    lane_h = (lsu_req.byteenable[2] == 1) ? lsu_req.ldata[31:16] : lsu_req.ldata[15:0];
  end

  always_comb begin
    result = lsu_req.ldata;  // lw passes the word.
    if (lsu_req.lsu_op.lsu_lb == 1) begin
      result = {{(`XLEN-8){lane_b[7]}}, lane_b};
    end else if (lsu_req.lsu_op.lsu_lbu == 1) begin
      result = {{(`XLEN-8){1'b0}}, lane_b};
    end else if (lsu_req.lsu_op.lsu_lh == 1) begin
      result = {{(`XLEN-16){lane_h[15]}}, lane_h};
    end else if (lsu_req.lsu_op.lsu_lhu == 1) begin
      result = {{(`XLEN-16){1'b0}}, lane_h};
    end
  end

endmodule

// File: rtl/mem_pkg.sv
`include "mem_defs.svh"

package mem_pkg;

  // one-hot load/store operation.
  typedef struct packed {
    logic lsu_lb;
    logic lsu_lh;
    logic lsu_lw;
    logic lsu_lbu;
    logic lsu_lhu;
    logic lsu_sb;
    logic lsu_sh;
    logic lsu_sw;
  } lsu_op_type;

  typedef struct packed {
    logic [`XLEN-1:0]   pc;
    logic               valid;
    logic               wren;
    logic [4:0]         waddr;
    logic [`XLEN-1:0]   wdata;      // alu result.
    logic               load;
    logic               store;
    logic               fence;
    logic [`XLEN-1:0]   address;
    logic [`XLEN-1:0]   sdata;      // store value, not yet aligned.
    logic [`XLEN/8-1:0] byteenable;
    lsu_op_type         lsu_op;
  } execute_out_type;

  typedef struct packed {
    logic               mem_valid;
    logic               mem_fence;
    logic [`XLEN-1:0]   mem_addr;
    logic [`XLEN-1:0]   mem_wdata;
    logic [`XLEN/8-1:0] mem_wstrb;
  } mem_in_type;

  typedef struct packed {
    logic             mem_ready;
    logic [`XLEN-1:0] mem_rdata;
  } mem_out_type;

  typedef struct packed {
    logic [`XLEN-1:0]   ldata;
    logic [`XLEN/8-1:0] byteenable;
    lsu_op_type         lsu_op;
  } lsu_in_type;

  typedef struct packed {
    logic             wren;
    logic [4:0]       waddr;
    logic [`XLEN-1:0] wdata;
  } register_write_type;

  typedef struct packed {
    logic               valid;
    logic               wren;
    logic [4:0]         waddr;
    logic [`XLEN-1:0]   wdata;
    logic               load;
    logic               store;
    logic               fence;
    logic [`XLEN/8-1:0] byteenable;
    lsu_op_type         lsu_op;
    logic               wren_b;     // enables saved across a stall.
    logic               valid_b;
    logic               fence_b;
    logic               stall;
    logic               clear;
  } memory_reg_type;

  localparam memory_reg_type init_memory_reg = '{
    valid: 1'b0, wren: 1'b0, waddr: '0, wdata: '0,
    load: 1'b0, store: 1'b0, fence: 1'b0, byteenable: '0, lsu_op: '0,
    wren_b: 1'b0, valid_b: 1'b0, fence_b: 1'b0, stall: 1'b0, clear: 1'b0
  };

  // replicate a byte or halfword over every byte lane.
  function automatic logic [`XLEN-1:0] store_data(input logic [`XLEN-1:0] sdata,
                                                  input logic sb, input logic sh,
                                                  input logic sw);
    logic [`XLEN-1:0] res;
    res = sdata;
    if (sb == 1) begin
      res = {4{sdata[7:0]}};
    end else if (sh == 1) begin
      res = {2{sdata[15:0]}};
    end else if (sw == 1) begin
      res = sdata;
    end
    return res;
  endfunction

endpackage

// File: rtl/mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// data and address width.
`define XLEN 32

// data memory depth in 32-bit words.
`define MEM_WORDS 256

// extra cycles before the memory answers a request.
// 0 gives a response in the cycle after acceptance.
`define MEM_WAIT 2

`endif
